//--- keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    // one-hot key codes as they come off the keypad
    localparam logic [15:0] KEY_ENTER   = 16'h0001;
    localparam logic [15:0] KEY_ADMIN   = 16'h0100;
    localparam logic [15:0] KEY_CLEAR   = 16'h1000;
    localparam logic [15:0] KEY_LOCK    = 16'h4000;
    localparam logic [15:0] KEY_DIGIT_0 = 16'h0008;
    localparam logic [15:0] KEY_DIGIT_1 = 16'h0080;
    localparam logic [15:0] KEY_DIGIT_2 = 16'h0040;
    localparam logic [15:0] KEY_DIGIT_3 = 16'h0020;
    localparam logic [15:0] KEY_DIGIT_4 = 16'h0800;
    localparam logic [15:0] KEY_DIGIT_5 = 16'h0400;
    localparam logic [15:0] KEY_DIGIT_6 = 16'h0200;
    localparam logic [15:0] KEY_DIGIT_7 = 16'h8000;
    localparam logic [15:0] KEY_DIGIT_8 = 16'h0010;
    localparam logic [15:0] KEY_DIGIT_9 = 16'h2000;

    localparam logic [3:0] DIGIT_BLANK = 4'hF;  // empty display digit
    localparam int         CODE_DIGITS = 3;     // digits in one code

    typedef enum logic [2:0] {
        op_digit,
        op_enter,
        op_clear,   // erase entry, close door
        op_admin,   // full reset incl. try count
        op_lock     // forced lockout
    } key_op_t;

endpackage

`default_nettype wire

//--- lock_pkg.sv
`default_nettype none

package lock_pkg;

    typedef enum logic [1:0] {
        st_entry,
        st_open,
        st_lockout
    } lock_state_t;

    typedef enum logic [1:0] {
        tone_key,
        tone_ok,
        tone_fail
    } tone_kind_t;

    localparam logic [11:0] PASSCODE     = 12'h246;  // BCD
    localparam int          MAX_TRIES    = 3;
    localparam int          LOCKOUT_SECS = 20;
    // lockout start value as two BCD digits
    localparam logic [7:0]  LOCKOUT_BCD  =
        8'(((LOCKOUT_SECS / 10) << 4) | (LOCKOUT_SECS % 10));

    localparam logic [11:0] OPEN_PATTERN  = 12'hBCC;  // reads "ASS"
    localparam logic [11:0] BLANK_PATTERN = 12'hFFF;

    // half period = TONE_DIV * multiplier
    localparam int KEY_MULT  = 2;
    localparam int OK_MULT   = 1;  // fast
    localparam int FAIL_MULT = 4;  // slow, also the largest

    // tone lengths in half periods
    localparam int KEY_LEN  = 8;
    localparam int OK_LEN   = 24;  // longest
    localparam int FAIL_LEN = 16;

    // fail tone is silent in half periods 5 to 8, zero-based indexes here
    localparam int FAIL_GAP_FIRST = 4;
    localparam int FAIL_GAP_LAST  = 7;

endpackage

`default_nettype wire

//--- keypad_decode.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_decode import keypad_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] keys,
    output logic        key_valid,
    output key_op_t     key_op,
    output logic [3:0]  key_digit
);

    logic [15:0] keys_prev;
    logic        legal;
    key_op_t     op;
    logic [3:0]  digit;
    logic        press;

    always_comb begin
        legal = 1'b1;
        op    = op_digit;
        digit = DIGIT_BLANK;
        case (keys)
            KEY_ENTER:   op = op_enter;
            KEY_CLEAR:   op = op_clear;
            KEY_ADMIN:   op = op_admin;
            KEY_LOCK:    op = op_lock;
            KEY_DIGIT_0: digit = 4'd0;
            KEY_DIGIT_1: digit = 4'd1;
            KEY_DIGIT_2: digit = 4'd2;
            KEY_DIGIT_3: digit = 4'd3;
            KEY_DIGIT_4: digit = 4'd4;
            KEY_DIGIT_5: digit = 4'd5;
            KEY_DIGIT_6: digit = 4'd6;
            KEY_DIGIT_7: digit = 4'd7;
            KEY_DIGIT_8: digit = 4'd8;
            KEY_DIGIT_9: digit = 4'd9;
            default:     legal = 1'b0;  // idle, unused or several keys
        endcase
    end

    assign press = legal && (keys_prev == 16'h0000);  // new press only

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keys_prev <= 16'h0000;
            key_valid <= 1'b0;
        end else begin
            keys_prev <= keys;
            key_valid <= press;
        end
    end

    always_ff @(posedge clk) begin
        if (press) begin
            key_op    <= op;
            key_digit <= digit;
        end
    end

    // a held key must give one strobe, never a second one next cycle
    a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |=> !key_valid);

endmodule

`default_nettype wire

//--- code_entry.sv
`timescale 1ns/1ps
`default_nettype none

module code_entry import keypad_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        key_valid,
    input  key_op_t     key_op,
    input  logic [3:0]  key_digit,
    input  logic        entry_enable,
    input  logic        entry_flush,
    output logic        cmd_valid,
    output key_op_t     cmd_op,
    output logic [11:0] entry_code,
    output logic [1:0]  entry_count
);

    logic full;

    assign full = (entry_count == 2'(CODE_DIGITS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid   <= 1'b0;
            entry_code  <= {3{DIGIT_BLANK}};
            entry_count <= 2'd0;
        end else begin
            cmd_valid <= 1'b0;
            if (entry_flush) begin  // controller consumed the code
                entry_code  <= {3{DIGIT_BLANK}};
                entry_count <= 2'd0;
            end
            if (key_valid) begin
                case (key_op)
                    op_digit: begin
                        if (entry_enable && !full) begin
                            entry_code  <= {entry_code[7:0], key_digit};  // shift left
                            entry_count <= entry_count + 2'd1;
                            cmd_valid   <= 1'b1;  // controller wants the click
                        end
                    end
                    op_enter: begin
                        if (entry_enable && full) begin
                            cmd_valid <= 1'b1;
                        end
                    end
                    op_clear: begin
                        entry_code  <= {3{DIGIT_BLANK}};
                        entry_count <= 2'd0;
                        cmd_valid   <= 1'b1;  // may close the door
                    end
                    default: begin
                        cmd_valid <= 1'b1;  // admin and lock always pass
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid) begin
            cmd_op <= key_op;
        end
    end

    // count stays in range and matches the blank nibbles on top
    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        (entry_count <= 2'(CODE_DIGITS)) &&
        ((entry_count == 2'(CODE_DIGITS)) || (entry_code[11:8] == DIGIT_BLANK)));

endmodule

`default_nettype wire

//--- lock_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lock_ctrl import keypad_pkg::*, lock_pkg::*; #(
    parameter int CLKS_PER_SEC = 50_000_000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_valid,
    input  key_op_t     cmd_op,
    input  logic [11:0] entry_code,
    output logic        entry_enable,
    output logic        entry_flush,
    output logic        tone_req,
    output tone_kind_t  tone_kind,
    output logic [11:0] display,
    output logic        door_open,
    output logic        locked_out
);

    localparam int SEC_W   = $clog2(CLKS_PER_SEC);
    localparam int TRIES_W = $clog2(MAX_TRIES + 1);

    lock_state_t        state, state_nxt;
    logic [TRIES_W-1:0] tries, tries_nxt;
    logic [7:0]         secs, secs_nxt;  // BCD seconds left
    logic [SEC_W-1:0]   sec_cnt, sec_cnt_nxt;
    logic               sec_tick;
    logic               flush_nxt;
    logic               tone_nxt;
    tone_kind_t         kind_nxt;
    logic [11:0]        display_nxt;

    assign sec_tick     = (state == st_lockout) && (sec_cnt == SEC_W'(CLKS_PER_SEC - 1));
    assign entry_enable = (state == st_entry);
    assign door_open    = (state == st_open);
    assign locked_out   = (state == st_lockout);

    always_comb begin
        state_nxt   = state;
        tries_nxt   = tries;
        secs_nxt    = secs;
        sec_cnt_nxt = sec_cnt;
        flush_nxt   = 1'b0;
        tone_nxt    = 1'b0;
        kind_nxt    = tone_kind;
        if (state == st_lockout) begin
            if (sec_tick) begin
                sec_cnt_nxt = '0;
                if (secs == 8'h00) begin
                    state_nxt = st_entry;  // would go below 00
                end else if (secs[3:0] == 4'd0) begin
                    secs_nxt = {secs[7:4] - 4'd1, 4'd9};
                end else begin
                    secs_nxt = {secs[7:4], secs[3:0] - 4'd1};
                end
            end else begin
                sec_cnt_nxt = sec_cnt + SEC_W'(1);
            end
        end
        if (cmd_valid) begin
            case (cmd_op)
                op_digit: begin
                    if (state == st_entry) begin
                        tone_nxt = 1'b1;
                        kind_nxt = tone_key;
                    end
                end
                op_enter: begin
                    if (state == st_entry) begin
                        flush_nxt = 1'b1;
                        tone_nxt  = 1'b1;
                        if (entry_code == PASSCODE) begin
                            state_nxt = st_open;
                            kind_nxt  = tone_ok;
                        end else begin
                            kind_nxt = tone_fail;
                            if (tries == TRIES_W'(MAX_TRIES - 1)) begin
                                state_nxt   = st_lockout;
                                secs_nxt    = LOCKOUT_BCD;
                                sec_cnt_nxt = '0;
                                tries_nxt   = '0;
                            end else begin
                                tries_nxt = tries + TRIES_W'(1);
                            end
                        end
                    end
                end
                op_clear: begin
                    if (state == st_open) begin
                        state_nxt = st_entry;  // close the door
                    end
                end
                op_admin: begin
                    state_nxt = st_entry;
                    tries_nxt = '0;
                    flush_nxt = 1'b1;
                end
                op_lock: begin
                    state_nxt   = st_lockout;
                    secs_nxt    = LOCKOUT_BCD;
                    sec_cnt_nxt = '0;
                    tries_nxt   = '0;
                    flush_nxt   = 1'b1;
                    tone_nxt    = 1'b1;
                    kind_nxt    = tone_fail;
                end
                default: ;
            endcase
        end
        case (state_nxt)
            st_open:    display_nxt = OPEN_PATTERN;
            st_lockout: display_nxt = {4'h0, secs_nxt};  // 0 then seconds
            default:    display_nxt = entry_code;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_entry;
            tries       <= '0;
            secs        <= 8'h00;
            sec_cnt     <= '0;
            entry_flush <= 1'b0;
            tone_req    <= 1'b0;
            tone_kind   <= tone_key;
            display     <= BLANK_PATTERN;
        end else begin
            state       <= state_nxt;
            tries       <= tries_nxt;
            secs        <= secs_nxt;
            sec_cnt     <= sec_cnt_nxt;
            entry_flush <= flush_nxt;
            tone_req    <= tone_nxt;
            tone_kind   <= kind_nxt;
            display     <= display_nxt;
        end
    end

    // digits and enter reach us only if the entry stage saw the lock in st_entry
    a_entry_gate: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid && (cmd_op == op_digit || cmd_op == op_enter)) |-> $past(entry_enable));

endmodule

`default_nettype wire

//--- alert_tone.sv
`timescale 1ns/1ps
`default_nettype none

module alert_tone import lock_pkg::*; #(
    parameter int TONE_DIV = 25_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tone_req,
    input  tone_kind_t tone_kind,
    output logic       buzzer
);

    localparam int HALF_W = $clog2(TONE_DIV * FAIL_MULT + 1);
    localparam int LEN_W  = $clog2(OK_LEN + 1);

    logic              active;
    tone_kind_t        kind;
    logic              phase;  // buzzer level without the gap
    logic [HALF_W-1:0] half_cnt;
    logic [HALF_W-1:0] half_last;
    logic [LEN_W-1:0]  len_cnt;  // current half period
    logic [LEN_W-1:0]  len_last;
    logic [LEN_W-1:0]  len_next;
    logic              half_end;
    logic              gap;

    always_comb begin
        case (kind)
            tone_ok: begin
                half_last = HALF_W'(TONE_DIV * OK_MULT - 1);
                len_last  = LEN_W'(OK_LEN - 1);
            end
            tone_fail: begin
                half_last = HALF_W'(TONE_DIV * FAIL_MULT - 1);
                len_last  = LEN_W'(FAIL_LEN - 1);
            end
            default: begin
                half_last = HALF_W'(TONE_DIV * KEY_MULT - 1);
                len_last  = LEN_W'(KEY_LEN - 1);
            end
        endcase
    end

    assign half_end = active && (half_cnt == half_last);
    assign len_next = len_cnt + LEN_W'(1);
    assign gap      = (kind == tone_fail) &&
                      (len_next >= LEN_W'(FAIL_GAP_FIRST)) &&
                      (len_next <= LEN_W'(FAIL_GAP_LAST));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            kind     <= tone_key;
            phase    <= 1'b0;
            half_cnt <= '0;
            len_cnt  <= '0;
            buzzer   <= 1'b0;
        end else if (tone_req) begin  // restart, drop any running tone
            active   <= 1'b1;
            kind     <= tone_kind;
            phase    <= 1'b1;
            half_cnt <= '0;
            len_cnt  <= '0;
            buzzer   <= 1'b1;
        end else if (active) begin
            if (half_end) begin
                half_cnt <= '0;
                if (len_cnt == len_last) begin
                    active <= 1'b0;
                    phase  <= 1'b0;
                    buzzer <= 1'b0;
                end else begin
                    len_cnt <= len_next;
                    phase   <= ~phase;
                    buzzer  <= ~phase & ~gap;  // muted in fail gap
                end
            end else begin
                half_cnt <= half_cnt + HALF_W'(1);
            end
        end
    end

    a_quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !active |-> !buzzer);

endmodule

`default_nettype wire

//--- code_lock_top.sv
`timescale 1ns/1ps
`default_nettype none

module code_lock_top import keypad_pkg::*, lock_pkg::*; #(
    parameter int CLKS_PER_SEC = 50_000_000,
    parameter int TONE_DIV     = 25_000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] keys,
    output logic [11:0] display,
    output logic        door_open,
    output logic        locked_out,
    output logic        buzzer
);

    logic        key_valid;
    key_op_t     key_op;
    logic [3:0]  key_digit;
    logic        cmd_valid;
    key_op_t     cmd_op;
    logic [11:0] entry_code;
    logic        entry_enable;
    logic        entry_flush;
    logic        tone_req;
    tone_kind_t  tone_kind;

    keypad_decode i_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .keys      (keys),
        .key_valid (key_valid),
        .key_op    (key_op),
        .key_digit (key_digit)
    );

    code_entry i_entry (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key_op       (key_op),
        .key_digit    (key_digit),
        .entry_enable (entry_enable),
        .entry_flush  (entry_flush),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .entry_code   (entry_code),
        .entry_count  ()  // only watched inside the entry stage
    );

    lock_ctrl #(
        .CLKS_PER_SEC (CLKS_PER_SEC)
    ) i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .entry_code   (entry_code),
        .entry_enable (entry_enable),
        .entry_flush  (entry_flush),
        .tone_req     (tone_req),
        .tone_kind    (tone_kind),
        .display      (display),
        .door_open    (door_open),
        .locked_out   (locked_out)
    );

    alert_tone #(
        .TONE_DIV (TONE_DIV)
    ) i_tone (
        .clk       (clk),
        .rst_n     (rst_n),
        .tone_req  (tone_req),
        .tone_kind (tone_kind),
        .buzzer    (buzzer)
    );

endmodule

`default_nettype wire

//--- tb_code_lock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_code_lock import lock_pkg::*; ;

    localparam int CLK_PERIOD   = 20;
    localparam int TB_CLKS      = 100;  // clocks per second in this run
    localparam int TB_TONE_DIV  = 4;
    localparam int PRESS_CYCLES = 8;    // 2 held, 6 released
    localparam int CHECK_DELAY  = 8;    // cycles from release to compare

    localparam logic [15:0] K_ENTER = 16'h0001;
    localparam logic [15:0] K_ADMIN = 16'h0100;
    localparam logic [15:0] K_CLEAR = 16'h1000;
    localparam logic [15:0] K_LOCK  = 16'h4000;

    localparam logic [11:0] PASS_CODE  = 12'h246;
    localparam logic [11:0] OPEN_CODE  = 12'hBCC;
    localparam logic [11:0] BLANK_CODE = 12'hFFF;
    localparam int          TRY_LIMIT  = 3;
    localparam int          LOCK_SECS  = 20;

    // key click is 8 half periods of 2 * TONE_DIV cycles
    localparam int CLICK_HALVES = 8;
    localparam int CLICK_CYCLES = CLICK_HALVES * 2 * TB_TONE_DIV;

    localparam int NUM_PRESSES = 53;
    localparam int RUN_CYCLES  = 14 + NUM_PRESSES * PRESS_CYCLES + (LOCK_SECS + 3) * TB_CLKS
                                 + 3 * CLICK_CYCLES + 6 * CHECK_DELAY;
    localparam int CYCLE_LIMIT = RUN_CYCLES * 12 / 10;

    typedef struct packed {
        lock_state_t st;
        logic [11:0] code;
        logic [1:0]  count;
        logic [1:0]  tries;
        int          lock_start;  // edge index where lockout began
    } model_t;

    logic        clk;
    logic        rst_n;
    logic [15:0] keys;
    logic [11:0] display;
    logic        door_open;
    logic        locked_out;
    logic        buzzer;

    int          cycle_cnt = 0;
    int          buzz_rises = 0;
    logic        buzzer_q = 1'b0;
    logic [16:0] lfsr_state;
    model_t      model;
    model_t      snap_q[$];
    int          due_q[$];
    int          idx_q[$];
    int          press_idx = 0;
    int          errors = 0;
    int          test_errors_base = 0;
    int          test_num = 0;
    int          ok_count = 0;
    int          fail_count = 0;

    code_lock_top #(
        .CLKS_PER_SEC (TB_CLKS),
        .TONE_DIV     (TB_TONE_DIV)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .keys       (keys),
        .display    (display),
        .door_open  (door_open),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        buzzer_q  <= buzzer;
        if (buzzer && !buzzer_q) begin
            buzz_rises <= buzz_rises + 1;
        end
    end

    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};  // x^17 + x^14 + 1
    endfunction

    function automatic logic [3:0] random_digit();
        logic [3:0] bits;
        int         i;
        bits = 4'd0;
        for (i = 0; i < 4; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[2:0], lfsr_state[0]};
        end
        return (bits > 4'd9) ? bits - 4'd6 : bits;
    endfunction

    function automatic logic [15:0] digit_key(input logic [3:0] d);
        case (d)
            4'd0:    return 16'h0008;
            4'd1:    return 16'h0080;
            4'd2:    return 16'h0040;
            4'd3:    return 16'h0020;
            4'd4:    return 16'h0800;
            4'd5:    return 16'h0400;
            4'd6:    return 16'h0200;
            4'd7:    return 16'h8000;
            4'd8:    return 16'h0010;
            4'd9:    return 16'h2000;
            default: return 16'h0000;
        endcase
    endfunction

    // lockout ends on the tick that would go below 00
    function automatic model_t settle(input model_t m_in, input int now);
        model_t m;
        m = m_in;
        if (m.st == st_lockout && (now - m.lock_start) >= (LOCK_SECS + 1) * TB_CLKS)
            m.st = st_entry;
        return m;
    endfunction

    function automatic model_t ref_step(input model_t m_in, input logic [15:0] key,
                                        input int sample);
        model_t     m;
        logic [3:0] d;
        logic       is_digit;
        int         i;
        m        = settle(m_in, sample);
        d        = 4'd0;
        is_digit = 1'b0;
        for (i = 0; i < 10; i++) begin
            if (key == digit_key(4'(i))) begin
                is_digit = 1'b1;
                d        = 4'(i);
            end
        end
        if (is_digit) begin
            if (m.st == st_entry && m.count < 2'd3) begin
                m.code  = {m.code[7:0], d};
                m.count = m.count + 2'd1;
            end
        end else if (key == K_ENTER) begin
            if (m.st == st_entry && m.count == 2'd3) begin
                if (m.code == PASS_CODE) begin
                    m.st = st_open;
                end else if (m.tries == 2'(TRY_LIMIT - 1)) begin
                    m.st         = st_lockout;
                    m.lock_start = sample + 2;  // decode, entry, control
                    m.tries      = 2'd0;
                end else begin
                    m.tries = m.tries + 2'd1;
                end
                m.code  = BLANK_CODE;
                m.count = 2'd0;
            end
        end else if (key == K_CLEAR || key == K_ADMIN || key == K_LOCK) begin
            m.code  = BLANK_CODE;
            m.count = 2'd0;
            if (key == K_CLEAR && m.st == st_open)
                m.st = st_entry;
            if (key == K_ADMIN) begin
                m.st    = st_entry;
                m.tries = 2'd0;
            end
            if (key == K_LOCK) begin
                m.st         = st_lockout;
                m.lock_start = sample + 2;
                m.tries      = 2'd0;
            end
        end
        return m;
    endfunction

    function automatic logic [11:0] ref_display(input model_t m_in, input int now);
        model_t m;
        int     secs;
        m    = settle(m_in, now);
        secs = LOCK_SECS - (now - m.lock_start) / TB_CLKS;
        case (m.st)
            st_open:    return OPEN_CODE;
            st_lockout: return {4'h0, 4'(secs / 10), 4'(secs % 10)};
            default:    return m.code;
        endcase
    endfunction

    task automatic check_display(input string name, input logic [11:0] got,
                                 input logic [11:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_buzzer(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_model(input model_t m, input string label);
        model_t s;
        int     now;
        now = cycle_cnt;
        s   = settle(m, now);
        check_display({label, " display"}, display, ref_display(m, now));
        check_flag({label, " door_open"}, door_open, s.st == st_open);
        check_flag({label, " locked_out"}, locked_out, s.st == st_lockout);
    endtask

    // compares each press against its snapshot once the pipeline has settled
    always @(negedge clk) begin
        while (due_q.size() != 0 && due_q[0] == cycle_cnt) begin
            compare_model(snap_q[0], $sformatf("press %0d", idx_q[0]));
            void'(due_q.pop_front());
            void'(snap_q.pop_front());
            void'(idx_q.pop_front());
        end
    end

    task automatic press_key(input logic [15:0] key);
        model = ref_step(model, key, cycle_cnt + 1);  // sampled on the next edge
        keys  = key;
        repeat (2) @(negedge clk);
        keys = 16'h0000;
        press_idx++;
        due_q.push_back(cycle_cnt + CHECK_DELAY);
        snap_q.push_back(model);
        idx_q.push_back(press_idx);
        repeat (PRESS_CYCLES - 2) @(negedge clk);
    endtask

    task automatic enter_code(input logic [11:0] code);
        press_key(digit_key(code[11:8]));
        press_key(digit_key(code[7:4]));
        press_key(digit_key(code[3:0]));
        press_key(K_ENTER);
    endtask

    task automatic enter_wrong_code();
        logic [11:0] code;
        code[11:8] = random_digit();
        code[7:4]  = random_digit();
        code[3:0]  = random_digit();
        if (code == PASS_CODE)
            code[3:0] = 4'd7;
        enter_code(code);
    endtask

    task automatic end_test(input string name);
        while (due_q.size() != 0) @(negedge clk);
        test_num++;
        if (errors == test_errors_base) begin
            ok_count++;
            $display("[%0d] %s: ok", test_num, name);
        end else begin
            fail_count++;
            $display("[%0d] %s: %0d wrong checks", test_num, name, errors - test_errors_base);
        end
        test_errors_base = errors;
    endtask

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int base;
        int n;
        int i;
        keys       = 16'h0000;
        rst_n      = 1'b0;
        lfsr_state = 17'd93579;
        model      = '{st: st_entry, code: BLANK_CODE, count: 2'd0, tries: 2'd0,
                       lock_start: 0};
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        repeat (4) @(negedge clk);
        compare_model(model, "after reset");
        check_buzzer("buzzer rises after reset", buzz_rises, 0);
        for (i = 0; i < 4; i++) begin
            press_key(digit_key(random_digit()));  // fourth one is dropped
        end
        press_key(K_CLEAR);
        end_test("reset and digit fill");

        enter_code(PASS_CODE);
        press_key(K_CLEAR);
        end_test("correct code opens, clear closes");

        enter_wrong_code();
        press_key(digit_key(random_digit()));
        press_key(digit_key(random_digit()));
        press_key(K_ENTER);  // only two digits, ignored
        press_key(K_ADMIN);
        end_test("wrong code and short entry");

        for (i = 0; i < TRY_LIMIT; i++) begin
            enter_wrong_code();
        end
        for (i = 0; i < 3; i++) begin
            press_key(digit_key(random_digit()));  // ignored in lockout
        end
        for (i = 0; i < LOCK_SECS + 2; i++) begin
            repeat (TB_CLKS) @(negedge clk);
            compare_model(model, $sformatf("lockout second %0d", i));
        end
        n = 0;
        while (locked_out && n < TB_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (locked_out) begin
            $display("locked_out still high %0d cycles after the lockout should end", n);
            errors++;
        end
        check_display("display after lockout", display, BLANK_CODE);
        check_flag("locked_out after lockout", locked_out, 1'b0);
        end_test("three failures lock out");

        press_key(K_LOCK);
        press_key(K_ADMIN);
        enter_wrong_code();  // one try on the count before admin
        press_key(K_ADMIN);
        enter_wrong_code();
        enter_wrong_code();
        while (due_q.size() != 0) @(negedge clk);
        check_flag("locked_out after two failures", locked_out, 1'b0);
        press_key(K_ADMIN);
        end_test("lock and admin keys");

        for (i = 0; i < 3; i++) begin
            base = buzz_rises;
            press_key(digit_key(random_digit()));
            check_buzzer("buzzer rises soon after key", buzz_rises - base, 1);
            repeat (CLICK_CYCLES) @(negedge clk);
            check_buzzer("buzzer rises over click", buzz_rises - base, CLICK_HALVES / 2);
            check_buzzer("buzzer level after click", int'(buzzer), 0);
        end
        press_key(K_CLEAR);
        end_test("key click");

        $display("tests %0d, ok %0d, failed %0d, wrong checks %0d",
                 test_num, ok_count, fail_count, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
keypad_pkg.sv
lock_pkg.sv
keypad_decode.sv
code_entry.sv
lock_ctrl.sv
alert_tone.sv
code_lock_top.sv
tb_code_lock.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_code_lock
FILELIST  = all.f

BUILD_DIR = obj_dir
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, a crash without a verdict also counts as failure
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
